// File: src.f
hisBuilderPkg.sv
histResultIf.sv
timestampFrontEnd.sv
histogramBank.sv
peakCombiner.sv
hisBuilderTop.sv
hisBuilderTb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the histogram builder testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=hisBuilderTb
BUILD_DIR=obj_dir
LOG_FILE=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

rm -rf "$BUILD_DIR"
rm -f "$LOG_FILE"

verilator --binary --timing -j 0 \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -o "V$TOP" \
    -f src.f
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    echo "build failed with status $buildStatus"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
fi

if grep -q "Verification passed" "$LOG_FILE"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: hisBuilderTb.sv
`timescale 1ns/1ps

module hisBuilderTb;

    localparam int Np = hisBuilderPkg::Np;
    localparam int Nb = hisBuilderPkg::Nb;
    localparam int Nf = hisBuilderPkg::Nf;
    // highest value a bin counter can hold
    localparam int satMax = 2 ** hisBuilderPkg::peakMax - 1;

    logic          clk = 1'b0;
    logic          reset;
    logic          wrEn;
    logic          acqFinish;
    logic [Np-1:0] roughData;
    logic          peakValid;
    logic [Np-1:0] peakTime;
    logic [Nb-1:0] coarsePeak;
    logic          fineHit;
    logic [15:0]   hisNum;

    integer        seed;
    int unsigned   cycleCount = 0;
    int            framesSent = 0;
    int            framesChecked = 0;
    logic [Nb-1:0] modelWindow;

    // events of the frame being built, then expected results per frame
    logic [Np-1:0] frameEvents [$];
    logic [Nb-1:0] expCoarseQ [$];
    logic          expFineHitQ [$];
    logic [Np-1:0] expTimeQ [$];
    int unsigned   expFinishQ [$];

    hisBuilderTop hisBuilderTop_inst (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .acqFinish  (acqFinish),
        .roughData  (roughData),
        .peakValid  (peakValid),
        .peakTime   (peakTime),
        .coarsePeak (coarsePeak),
        .fineHit    (fineHit),
        .hisNum     (hisNum)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic checkValue(input string field, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, field, actual, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    // histogram of one frame, peak is the first bin to reach the strict maximum
    function automatic void refFrame(input logic [Np-1:0] events [$],
                                     input logic [Nb-1:0] window,
                                     output logic [Nb-1:0] coarsePk,
                                     output logic [Nf-1:0] finePk,
                                     output logic fineAny,
                                     output logic [Np-1:0] timeOut,
                                     output logic [Nb-1:0] nextWindow);
        int            coarseCnt [2**Nb];
        int            fineCnt [2**Nf];
        int            coarseBest;
        int            fineBest;
        logic [Nb-1:0] cb;
        logic [Nf-1:0] fb;
        for (int i = 0; i < 2**Nb; i++) coarseCnt[i] = 0;
        for (int i = 0; i < 2**Nf; i++) fineCnt[i] = 0;
        coarseBest = 0;
        fineBest = 0;
        coarsePk = '0;
        finePk = '0;
        foreach (events[i]) begin
            cb = events[i][Np-1 -: Nb];
            fb = events[i][Nf-1:0];
            if (coarseCnt[cb] < satMax) coarseCnt[cb]++;
            if (coarseCnt[cb] > coarseBest) begin
                coarseBest = coarseCnt[cb];
                coarsePk = cb;
            end
            // fine bank only sees events inside the window
            if (cb == window) begin
                if (fineCnt[fb] < satMax) fineCnt[fb]++;
                if (fineCnt[fb] > fineBest) begin
                    fineBest = fineCnt[fb];
                    finePk = fb;
                end
            end
        end
        fineAny = (fineBest != 0);
        timeOut = {window, finePk};
        // an empty coarse histogram leaves the window where it was
        nextWindow = (coarseBest != 0) ? coarsePk : window;
    endfunction

    function automatic logic [Np-1:0] makeStamp(input logic [Nb-1:0] coarse,
                                                 input logic [Nf-1:0] fine);
        return {coarse, fine};
    endfunction

    // one event per cycle, wrEn stays high until the frame ends
    task automatic sendEvent(input logic [Np-1:0] stamp);
        @(posedge clk);
        wrEn <= 1'b1;
        roughData <= stamp;
        frameEvents.push_back(stamp);
    endtask

    // acqFinish pulse, optionally with an event that must be dropped
    task automatic endFrame(input logic dropOn, input logic [Np-1:0] dropStamp);
        logic [Nb-1:0] cPk;
        logic [Nf-1:0] fPk;
        logic          fAny;
        logic [Np-1:0] pTime;
        logic [Nb-1:0] nextWin;
        @(posedge clk);
        wrEn <= dropOn;
        roughData <= dropStamp;
        acqFinish <= 1'b1;
        @(posedge clk);
        wrEn <= 1'b0;
        acqFinish <= 1'b0;
        // counter value of the cycle in which acqFinish is high
        expFinishQ.push_back(cycleCount);
        refFrame(frameEvents, modelWindow, cPk, fPk, fAny, pTime, nextWin);
        modelWindow = nextWin;
        expCoarseQ.push_back(cPk);
        expFineHitQ.push_back(fAny);
        expTimeQ.push_back(pTime);
        frameEvents.delete();
        framesSent++;
        // new window must be in place before the next event
        repeat (4) @(posedge clk);
    endtask

    // random timestamps, a share of them forced into the window
    task automatic randomFrame(input int numEvents, input int windowShare);
        int pick;
        for (int i = 0; i < numEvents; i++) begin
            pick = {$random(seed)} % 100;
            if (pick < windowShare) begin
                sendEvent(makeStamp(modelWindow, Nf'($random(seed))));
            end else begin
                sendEvent(Np'($random(seed)));
            end
        end
        endFrame(1'b0, '0);
    endtask

    // compare process, one result per peakValid
    initial begin : compareProc
        int waitCount;
        int expHisNum;
        waitCount = 0;
        expHisNum = 0;
        forever begin
            @(negedge clk);
            if (peakValid === 1'b1) begin
                if (expTimeQ.size() == 0) begin
                    $display("peakValid pulsed while no frame was outstanding");
                    $display("Verification failed");
                    $fatal(1, "unexpected result");
                end else begin
                    expHisNum++;
                    checkValue("latency", 32'(cycleCount - expFinishQ.pop_front()), 3);
                    checkValue("coarsePeak", 32'(coarsePeak), 32'(expCoarseQ.pop_front()));
                    checkValue("fineHit", 32'(fineHit), 32'(expFineHitQ.pop_front()));
                    checkValue("peakTime", 32'(peakTime), 32'(expTimeQ.pop_front()));
                    checkValue("hisNum", 32'(hisNum), expHisNum);
                    framesChecked++;
                    waitCount = 0;
                end
            end else if (expTimeQ.size() != 0) begin
                waitCount++;
                if (waitCount > 20) begin
                    $display("peakValid did not arrive after acqFinish");
                    $display("Verification failed");
                    $fatal(1, "timeout waiting for peakValid");
                end
            end
        end
    end

    initial begin : stimulusProc
        int waitCount;
        seed = 98009;
        reset <= 1'b1;
        wrEn <= 1'b0;
        acqFinish <= 1'b0;
        roughData <= '0;
        modelWindow = Nb'(hisBuilderPkg::windowReset);
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // idle outputs right after reset
        @(negedge clk);
        checkValue("peakValid", 32'(peakValid), 0);
        checkValue("hisNum", 32'(hisNum), 0);
        checkValue("coarsePeak", 32'(coarsePeak), 0);
        checkValue("fineHit", 32'(fineHit), 0);
        checkValue("peakTime", 32'(peakTime), 0);

        // empty first frame
        endFrame(1'b0, '0);

        // random coarse peak, then a tie that bin 7 reaches before the lower bin 3
        randomFrame(60, 0);
        sendEvent(makeStamp(5'd3, 5'd2));
        sendEvent(makeStamp(5'd7, 5'd1));
        sendEvent(makeStamp(5'd7, 5'd8));
        sendEvent(makeStamp(5'd3, 5'd4));
        endFrame(1'b0, '0);

        // refined peak inside the window from the tie frame
        randomFrame(80, 50);

        // all events miss the window, then an empty frame keeps it
        for (int i = 0; i < 12; i++) begin
            sendEvent(makeStamp(modelWindow + Nb'(1), Nf'($random(seed))));
        end
        endFrame(1'b0, '0);
        endFrame(1'b0, '0);

        // event on the acqFinish cycle would otherwise move the peak to bin 12
        sendEvent(makeStamp(5'd10, 5'd1));
        sendEvent(makeStamp(5'd10, 5'd2));
        sendEvent(makeStamp(5'd12, 5'd3));
        sendEvent(makeStamp(5'd12, 5'd3));
        endFrame(1'b1, makeStamp(5'd12, 5'd3));

        // bin 5 saturates first, bin 9 can only tie at 255
        for (int i = 0; i < 260; i++) sendEvent(makeStamp(5'd5, Nf'(i % 3)));
        for (int i = 0; i < 300; i++) sendEvent(makeStamp(5'd9, Nf'(i)));
        endFrame(1'b0, '0);

        // back-to-back random frames
        for (int f = 0; f < 20; f++) begin
            randomFrame(20 + {$random(seed)} % 60, 40);
        end

        waitCount = 0;
        while (framesChecked != framesSent) begin
            @(negedge clk);
            waitCount++;
            if (waitCount > 50) begin
                $display("frame results still outstanding after the last frame");
                $display("Verification failed");
                $fatal(1, "timeout waiting for final results");
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: hisBuilderTop.sv
`timescale 1ns/1ps

module hisBuilderTop #(
    parameter int coarseBits = hisBuilderPkg::Nb,
    parameter int fineBits   = hisBuilderPkg::Nf
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wrEn,
    input  logic                         acqFinish,
    input  logic [hisBuilderPkg::Np-1:0] roughData,
    output logic                         peakValid,
    output logic [hisBuilderPkg::Np-1:0] peakTime,
    output logic [coarseBits-1:0]        coarsePeak,
    output logic                         fineHit,
    output logic [15:0]                  hisNum
);

    // event stream into the coarse bank
    logic                  coarseEventHit;
    logic [coarseBits-1:0] coarseBin;

    // window-qualified stream into the fine bank
    logic                  fineEventHit;
    logic [fineBits-1:0]   fineBin;

    // frame boundary shared by both banks
    logic frameEnd;

    // current coarse window, fed back from the combiner
    logic [coarseBits-1:0] window;

    // per-bank frame results
    histResultIf #(.binBits(coarseBits)) coarseRes ();
    histResultIf #(.binBits(fineBits))   fineRes ();

    timestampFrontEnd #(
        .coarseBits (coarseBits),
        .fineBits   (fineBits)
    ) timestampFrontEnd_inst (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .acqFinish  (acqFinish),
        .roughData  (roughData),
        .window     (window),
        .coarseHit  (coarseEventHit),
        .coarseBin  (coarseBin),
        .fineHit    (fineEventHit),
        .fineBin    (fineBin),
        .frameEnd   (frameEnd)
    );

    // every event, binned by its coarse field
    histogramBank #(
        .binBits (coarseBits)
    ) coarseBank (
        .clk      (clk),
        .reset    (reset),
        .hit      (coarseEventHit),
        .bin      (coarseBin),
        .frameEnd (frameEnd),
        .result   (coarseRes.bank)
    );

    // only events inside the window, binned by their fine field
    histogramBank #(
        .binBits (fineBits)
    ) fineBank (
        .clk      (clk),
        .reset    (reset),
        .hit      (fineEventHit),
        .bin      (fineBin),
        .frameEnd (frameEnd),
        .result   (fineRes.bank)
    );

    peakCombiner #(
        .coarseBits (coarseBits),
        .fineBits   (fineBits)
    ) peakCombiner_inst (
        .clk        (clk),
        .reset      (reset),
        .coarseRes  (coarseRes.combiner),
        .fineRes    (fineRes.combiner),
        .window     (window),
        .peakValid  (peakValid),
        .peakTime   (peakTime),
        .coarsePeak (coarsePeak),
        .fineHit    (fineHit),
        .hisNum     (hisNum)
    );

endmodule

// File: peakCombiner.sv
`timescale 1ns/1ps

module peakCombiner #(
    parameter int coarseBits = 5,
    parameter int fineBits   = 5
) (
    input  logic                         clk,
    input  logic                         reset,
    histResultIf.combiner                coarseRes,
    histResultIf.combiner                fineRes,
    output logic [coarseBits-1:0]        window,
    output logic                         peakValid,
    output logic [hisBuilderPkg::Np-1:0] peakTime,
    output logic [coarseBits-1:0]        coarsePeak,
    output logic                         fineHit,
    output logic [15:0]                  hisNum
);

    // both banks finish on the same edge
    logic frameDone;

    // window follows the coarse peak, but only when it exists
    logic windowLoad;

    assign frameDone  = coarseRes.done & fineRes.done;
    assign windowLoad = frameDone & ~coarseRes.empty;

    // coarse window register
    // the fine bank was filled against the value held here
    always_ff @(posedge clk) begin
        if (reset) begin
            window <= coarseBits'(hisBuilderPkg::windowReset);
        end else if (windowLoad) begin
            window <= coarseRes.peakBin;
        end
    end

    // frame counter and valid strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            peakValid <= 1'b0;
            hisNum    <= '0;
        end else begin
            peakValid <= frameDone;
            if (frameDone) begin
                hisNum <= hisNum + 16'd1;
            end
        end
    end

    // output fields, idle at zero until the first frame
    always_ff @(posedge clk) begin
        if (reset) begin
            peakTime   <= '0;
            coarsePeak <= '0;
            fineHit    <= 1'b0;
        end else if (frameDone) begin
            // old window on top, fine peak below
            peakTime   <= {window, fineRes.peakBin};
            coarsePeak <= coarseRes.peakBin;
            fineHit    <= ~fineRes.empty;
        end
    end

endmodule

// File: histogramBank.sv
`timescale 1ns/1ps

module histogramBank #(
    parameter int binBits = 5
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               hit,
    input  logic [binBits-1:0] bin,
    input  logic               frameEnd,
    histResultIf.bank          result
);

    localparam int numBins = 2 ** binBits;

    // one saturating counter per bin
    hisBuilderPkg::binCount_t binCounts [numBins];

    // incremented value of the addressed bin
    hisBuilderPkg::binCount_t nextCount;

    // running peak, kept current so frame end needs no scan
    hisBuilderPkg::binCount_t peakCount;
    logic [binBits-1:0]       peakBin;

    // saturating increment
    always_comb begin
        nextCount = binCounts[bin];
        if (nextCount != '1) begin
            nextCount = nextCount + hisBuilderPkg::binCount_t'(1);
        end
    end

    // bin counters, wiped at reset and at every frame end
    always_ff @(posedge clk) begin
        if (reset || frameEnd) begin
            for (int i = 0; i < numBins; i++) begin
                binCounts[i] <= '0;
            end
        end else if (hit) begin
            binCounts[bin] <= nextCount;
        end
    end

    // peak tracker
    // strictly greater, so on a tie the earlier bin keeps the peak
    // a saturated bin never beats another saturated one
    always_ff @(posedge clk) begin
        if (reset || frameEnd) begin
            peakCount <= '0;
            peakBin   <= '0;
        end else if (hit && (nextCount > peakCount)) begin
            peakCount <= nextCount;
            peakBin   <= bin;
        end
    end

    // result strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            result.done <= 1'b0;
        end else begin
            result.done <= frameEnd;
        end
    end

    // result fields captured on frame end
    // empty frame leaves bin 0 with count 0
    always_ff @(posedge clk) begin
        if (frameEnd) begin
            result.peakBin   <= peakBin;
            result.peakCount <= peakCount;
            result.empty     <= (peakCount == '0);
        end
    end

endmodule

// File: timestampFrontEnd.sv
`timescale 1ns/1ps

module timestampFrontEnd #(
    parameter int coarseBits = 5,
    parameter int fineBits   = 5
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wrEn,
    input  logic                         acqFinish,
    input  logic [hisBuilderPkg::Np-1:0] roughData,
    input  logic [coarseBits-1:0]        window,
    output logic                         coarseHit,
    output logic [coarseBits-1:0]        coarseBin,
    output logic                         fineHit,
    output logic [fineBits-1:0]          fineBin,
    output logic                         frameEnd
);

    // timestamp split into its two fields
    logic [coarseBits-1:0] rawCoarse;
    logic [fineBits-1:0]   rawFine;

    // event accepted into the current frame
    logic eventValid;

    // coarse field is the top of the timestamp
    assign rawCoarse = roughData[hisBuilderPkg::Np-1 -: coarseBits];
    assign rawFine   = roughData[fineBits-1:0];

    // an event on the acqFinish cycle belongs to no frame
    assign eventValid = wrEn & ~acqFinish;

    // strobes, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            coarseHit <= 1'b0;
            fineHit   <= 1'b0;
            frameEnd  <= 1'b0;
        end else begin
            coarseHit <= eventValid;
            // window compare uses the window of this very cycle
            fineHit   <= eventValid && (rawCoarse == window);
            // same stage as the hits so banks see a clean boundary
            frameEnd  <= acqFinish;
        end
    end

    // bin addresses, only looked at together with a hit
    always_ff @(posedge clk) begin
        coarseBin <= rawCoarse;
        fineBin   <= rawFine;
    end

endmodule

// File: histResultIf.sv
`timescale 1ns/1ps

// end-of-frame result of one histogram bank
interface histResultIf #(
    parameter int binBits = 5
) ();

    // single-cycle strobe, fields below valid with it
    logic done;

    // bin that reached the highest count first
    logic [binBits-1:0] peakBin;

    // count held by that bin
    hisBuilderPkg::binCount_t peakCount;

    // no event landed in this bank during the frame
    logic empty;

    modport bank (
        output done,
        output peakBin,
        output peakCount,
        output empty
    );

    modport combiner (
        input done,
        input peakBin,
        input peakCount,
        input empty
    );

endinterface

// File: hisBuilderPkg.sv
package hisBuilderPkg;

    // raw timestamp width from the TDC
    parameter int Np = 10;

    // coarse bin takes the upper bits of the timestamp
    parameter int Nb = 5;

    // fine bin is whatever is left below the coarse field
    parameter int Nf = Np - Nb;

    // bin counter width
    parameter int peakMax = 8;

    // one histogram bin, saturates at all ones
    typedef logic [peakMax-1:0] binCount_t;

    // coarse window before any frame has finished
    // narrowed to the coarse width where it is loaded
    parameter int windowReset = 0;

endpackage
